/* build.f */
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_port_pkg.sv
logic/noc_input_fifo.sv
logic/noc_xy_route.sv
logic/noc_rr_arbiter.sv
logic/noc_mesh_router.sv
verif/noc_router_sva.sv
verif/noc_router_tb.sv

/* logic/noc_consts.svh */
// ********************
// Router build constants: coordinate and payload widths,
// input FIFO depth and number of router ports
// ********************

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Width of one X or Y mesh coordinate
`define NOC_COORD_W 4

// Payload bits carried by one flit
`define NOC_DATA_W 32

// Entries in each input FIFO
`define NOC_FIFO_DEPTH 4

// North, east, south, west and local
`define NOC_NUM_PORTS 5

`endif

/* logic/noc_flit_pkg.sv */
// ********************
// Flit format: mesh coordinate type and the flit struct
// ********************

`include "noc_consts.svh"

package noc_flit_pkg;

    // One X or Y position in the mesh
    typedef logic [`NOC_COORD_W-1:0] coord_t;

    // Single-flit packet
    // Destination sits in the upper bits, payload below it
    typedef struct packed {
        coord_t                  dest_x;
        coord_t                  dest_y;
        logic [`NOC_DATA_W-1:0]  data;
    } flit_t;

endpackage

/* logic/noc_input_fifo.sv */
// ********************
// Input FIFO for one router port
// Circular flit buffer, ready taken from occupancy
// ********************

`timescale 1ns/100ps

`include "noc_consts.svh"

module noc_input_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push_i,
    input  noc_flit_pkg::flit_t push_flit_i,
    output logic                ready_o,
    input  logic                pop_i,
    output noc_flit_pkg::flit_t head_o,
    output logic                not_empty_o
);

    localparam int DEPTH   = `NOC_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    noc_flit_pkg::flit_t mem [DEPTH];
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [COUNT_W-1:0]  count_q;
    logic                push_ok;

    // Full exactly at DEPTH entries, so a pop does not reopen ready in the same cycle
    assign ready_o     = (count_q != COUNT_W'(DEPTH));
    assign not_empty_o = (count_q != '0);
    assign push_ok     = push_i & ready_o;
    assign head_o      = mem[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                mem[k] <= '0;
            end
        end else begin
            if (push_ok) begin
                mem[wr_ptr_q] <= push_flit_i;
                if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end

            // Caller only pops a non-empty buffer
            if (pop_i) begin
                if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end

            case ({push_ok, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* logic/noc_mesh_router.sv */
// ********************
// Five-port mesh router top: input FIFOs, XY route units,
// per-output round-robin arbiters and the crossbar
// ********************

`timescale 1ns/100ps

`include "noc_consts.svh"

module noc_mesh_router (
    input  logic                     clk,
    input  logic                     rst_n,

    // Position of this router in the mesh
    input  noc_flit_pkg::coord_t     local_x_i,
    input  noc_flit_pkg::coord_t     local_y_i,

    // Input links, indexed by port_e
    input  noc_port_pkg::port_mask_t in_valid_i,
    input  noc_flit_pkg::flit_t      in_flit_i [`NOC_NUM_PORTS],
    output noc_port_pkg::port_mask_t in_ready_o,

    // Output links, indexed by port_e
    output noc_port_pkg::port_mask_t out_valid_o,
    output noc_flit_pkg::flit_t      out_flit_o [`NOC_NUM_PORTS],
    input  noc_port_pkg::port_mask_t out_ready_i
);

    localparam int NUM_PORTS = `NOC_NUM_PORTS;

    // Per-input side
    noc_flit_pkg::flit_t      fifo_head [NUM_PORTS];
    noc_port_pkg::port_mask_t fifo_not_empty;
    noc_port_pkg::port_mask_t fifo_pop;
    noc_port_pkg::port_mask_t route_req [NUM_PORTS];

    // Per-output side, each mask spans the inputs
    noc_port_pkg::port_mask_t out_req [NUM_PORTS];
    noc_port_pkg::port_mask_t out_grant [NUM_PORTS];
    noc_port_pkg::port_mask_t out_accept;

    // Input buffering and route computation
    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_input
        noc_input_fifo noc_input_fifo_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (in_valid_i[i]),
            .push_flit_i (in_flit_i[i]),
            .ready_o     (in_ready_o[i]),
            .pop_i       (fifo_pop[i]),
            .head_o      (fifo_head[i]),
            .not_empty_o (fifo_not_empty[i])
        );

        noc_xy_route noc_xy_route_inst (
            .head_i    (fifo_head[i]),
            .valid_i   (fifo_not_empty[i]),
            .local_x_i (local_x_i),
            .local_y_i (local_y_i),
            .request_o (route_req[i])
        );
    end

    // Transpose: output j sees bit j of every input's request
    always_comb begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                out_req[j][i] = route_req[i][j];
            end
        end
    end

    // One arbiter per output
    for (genvar j = 0; j < NUM_PORTS; j++) begin : gen_output
        noc_rr_arbiter noc_rr_arbiter_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .request_i (out_req[j]),
            .accept_i  (out_accept[j]),
            .grant_o   (out_grant[j])
        );

        // Valid does not look at the downstream ready
        assign out_valid_o[j] = |out_grant[j];
    end

    // The only place where a completed output transfer is decided
    assign out_accept = out_valid_o & out_ready_i;

    // Crossbar, AND-OR over one-hot grants
    always_comb begin
        for (int j = 0; j < NUM_PORTS; j++) begin
            out_flit_o[j] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (out_grant[j][i]) begin
                    out_flit_o[j] = out_flit_o[j] | fifo_head[i];
                end
            end
        end
    end

    // An input requests a single output, so at most one accept can pop it
    always_comb begin
        fifo_pop = '0;
        for (int j = 0; j < NUM_PORTS; j++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                fifo_pop[i] = fifo_pop[i] | (out_accept[j] & out_grant[j][i]);
            end
        end
    end

endmodule

/* logic/noc_port_pkg.sv */
// ********************
// Router port types: port index enum and per-port mask
// ********************

`include "noc_consts.svh"

package noc_port_pkg;

    // Port indices, also the bit positions in port_mask_t
    typedef enum logic [2:0] {
        PORT_NORTH = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_LOCAL = 3'd4
    } port_e;

    // One bit per port, used for requests, grants and link handshakes
    typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

endpackage

/* logic/noc_rr_arbiter.sv */
// ********************
// Round-robin arbiter for one output port
// ********************

`timescale 1ns/100ps

`include "noc_consts.svh"

module noc_rr_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  noc_port_pkg::port_mask_t request_i,
    input  logic                     accept_i,
    output noc_port_pkg::port_mask_t grant_o
);

    localparam int NUM_PORTS = `NOC_NUM_PORTS;
    localparam int PTR_W     = $clog2(NUM_PORTS);

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] win_idx;
    logic             hold_q;
    logic [PTR_W-1:0] hold_idx_q;

    // First requester at or after the pointer, cyclic order
    always_comb begin
        int   idx;
        logic found;
        // A winner still waiting for ready keeps the output
        grant_o          = '0;
        win_idx          = hold_q ? hold_idx_q : ptr_q;
        found            = hold_q;
        grant_o[win_idx] = hold_q;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(ptr_q) + k) % NUM_PORTS;
            if (!found && request_i[idx]) begin
                grant_o[idx] = 1'b1;
                win_idx      = PTR_W'(idx);
                found        = 1'b1;
            end
        end
    end

    // Pointer holds under back-pressure so the grant stays put
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            // Granted input keeps its request until its flit is taken
            hold_q     <= (|grant_o) & ~accept_i;
            hold_idx_q <= win_idx;
            if (accept_i) begin
                if (win_idx == PTR_W'(NUM_PORTS - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= win_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/noc_xy_route.sv */
// ********************
// XY route decision for one head flit
// ********************

`timescale 1ns/100ps

module noc_xy_route (
    input  noc_flit_pkg::flit_t      head_i,
    input  logic                     valid_i,
    input  noc_flit_pkg::coord_t     local_x_i,
    input  noc_flit_pkg::coord_t     local_y_i,
    output noc_port_pkg::port_mask_t request_o
);

    noc_port_pkg::port_e dir;

    // X is resolved before Y
    always_comb begin
        if (head_i.dest_x > local_x_i) begin
            dir = noc_port_pkg::PORT_EAST;
        end else if (head_i.dest_x < local_x_i) begin
            dir = noc_port_pkg::PORT_WEST;
        end else if (head_i.dest_y > local_y_i) begin
            dir = noc_port_pkg::PORT_SOUTH;
        end else if (head_i.dest_y < local_y_i) begin
            dir = noc_port_pkg::PORT_NORTH;
        end else begin
            // Arrived
            dir = noc_port_pkg::PORT_LOCAL;
        end
    end

    // One-hot while a head flit exists, zero otherwise
    always_comb begin
        request_o      = '0;
        request_o[dir] = valid_i;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module noc_router_tb -o noc_router_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/noc_router_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

/* verif/noc_router_sva.sv */
// ********************
// Router output assertions: grant shape,
// held outputs and requested grants
// ********************

`timescale 1ns/100ps

`include "noc_consts.svh"

module noc_router_sva (
    input logic                     clk,
    input logic                     rst_n,
    input noc_port_pkg::port_mask_t out_valid_o,
    input noc_port_pkg::port_mask_t out_ready_i,
    input noc_flit_pkg::flit_t      out_flit_o [`NOC_NUM_PORTS],
    input noc_port_pkg::port_mask_t out_grant [`NOC_NUM_PORTS],
    input noc_port_pkg::port_mask_t out_req [`NOC_NUM_PORTS]
);

    for (genvar j = 0; j < `NOC_NUM_PORTS; j++) begin : gen_check
        // At most one input wins an output
        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(out_grant[j]))
            else $error("Grant on output %0d is not one-hot", j);

        // Grants only go to requesting inputs
        // Valid therefore never rises on an output nobody routes to
        a_grant_requested: assert property (@(posedge clk) disable iff (!rst_n)
            (out_grant[j] & ~out_req[j]) == '0)
            else $error("Output %0d granted an input without a request", j);

        // A held output keeps valid and its flit until taken
        a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid_o[j] && !out_ready_i[j] |=> out_valid_o[j] && $stable(out_flit_o[j]))
            else $error("Valid or flit changed on output %0d under back-pressure", j);
    end

endmodule

bind noc_mesh_router noc_router_sva noc_router_sva_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_flit_o  (out_flit_o),
    .out_grant   (out_grant),
    .out_req     (out_req)
);

/* verif/noc_router_tb.sv */
// ********************
// Router testbench: clock, reset, random traffic,
// queue model, checks and report
// ********************

`timescale 1ns/100ps

`include "noc_consts.svh"

module noc_router_tb;

    localparam int NP    = `NOC_NUM_PORTS;
    localparam int LOC_X = 5;
    localparam int LOC_Y = 6;

    logic clk;
    logic rst_n;
    noc_flit_pkg::coord_t     local_x;
    noc_flit_pkg::coord_t     local_y;
    noc_port_pkg::port_mask_t in_valid, in_ready, out_valid, out_ready, in_fire;
    noc_flit_pkg::flit_t      in_flit [NP];
    noc_flit_pkg::flit_t      out_flit [NP];

    // Model queue per (input, output) pair, index input*NP + output
    noc_flit_pkg::flit_t model_q [NP*NP][$];
    logic [7:0] east_src [$];
    logic       track_east;
    integer     seed;
    int         errors, checks, seq;
    int         acc_cnt [NP];

    noc_mesh_router noc_mesh_router_inst (
        .clk(clk), .rst_n(rst_n), .local_x_i(local_x), .local_y_i(local_y),
        .in_valid_i(in_valid), .in_flit_i(in_flit), .in_ready_o(in_ready),
        .out_valid_o(out_valid), .out_flit_o(out_flit), .out_ready_i(out_ready)
    );

    always #10 clk = ~clk;

    function automatic int xy_port(input noc_flit_pkg::flit_t f);
        if (int'(f.dest_x) > LOC_X) return 1;
        if (int'(f.dest_x) < LOC_X) return 3;
        if (int'(f.dest_y) > LOC_Y) return 2;
        if (int'(f.dest_y) < LOC_Y) return 0;
        return 4;
    endfunction

    function automatic bit model_empty();
        for (int q = 0; q < NP*NP; q++) begin
            if (model_q[q].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // Transfers seen at the falling edge complete on the next rising edge
    always @(negedge clk) begin
        int   q;
        logic found;
        if (rst_n) begin
            for (int j = 0; j < NP; j++) begin
                if (out_valid[j] && out_ready[j]) begin
                    found = 1'b0;
                    for (int i = 0; i < NP; i++) begin
                        q = i * NP + j;
                        if (!found && model_q[q].size() > 0 && model_q[q][0] == out_flit[j]) begin
                            void'(model_q[q].pop_front());
                            found = 1'b1;
                        end
                    end
                    if (track_east && j == 1) east_src.push_back(out_flit[j].data[31:24]);
                    check_value($sformatf("out_port%0d_match", j), 1, found);
                end
            end
            in_fire = in_valid & in_ready;
            for (int i = 0; i < NP; i++) begin
                if (in_fire[i]) begin
                    model_q[i * NP + xy_port(in_flit[i])].push_back(in_flit[i]);
                    acc_cnt[i]++;
                end
            end
        end
    end

    task automatic drive_cycle(input noc_port_pkg::port_mask_t en, input int pct,
                               input bit east_only, input bit rdy_rand,
                               input noc_port_pkg::port_mask_t rdy);
        noc_flit_pkg::flit_t f;
        @(posedge clk);
        for (int i = 0; i < NP; i++) begin
            // A pending flit stays until it is taken
            if (!in_valid[i] || in_fire[i]) begin
                if (en[i] && (($random(seed) & 32'h7fffffff) % 100) < pct) begin
                    f.dest_x = east_only ? 4'd9 : 4'($random(seed));
                    f.dest_y = 4'($random(seed));
                    f.data   = {8'(i), 24'(seq)};
                    seq++;
                    in_valid[i] <= 1'b1;
                    in_flit[i]  <= f;
                end else begin
                    in_valid[i] <= 1'b0;
                end
            end
        end
        out_ready <= rdy_rand ? 5'($random(seed)) : rdy;
        @(negedge clk);
        #1;
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        while (!(in_valid == '0 && out_valid == '0 && model_empty()) && n < 500) begin
            drive_cycle('0, 0, 0, 0, '1);
            n++;
        end
        if (n >= 500) begin
            errors++;
            $display("Test %s: timed out waiting for the router to drain", name);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("Test %s finished: %0d errors", name, errors - err_start);
    endtask

    initial begin
        int e, src, start, n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        seed       = 32'hb9f558bb;
        errors     = 0;
        checks     = 0;
        seq        = 0;
        track_east = 1'b0;
        local_x    = LOC_X;
        local_y    = LOC_Y;
        in_valid   = '0;
        out_ready  = '0;
        in_fire    = '0;
        for (int i = 0; i < NP; i++) begin
            in_flit[i] = '0;
            acc_cnt[i] = 0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        e = errors;
        check_value("reset_out_valid", 0, out_valid);
        check_value("reset_in_ready", 5'h1f, in_ready);
        report_test("reset", e);

        e = errors;
        for (int k = 0; k < 20; k++) begin
            src = ($random(seed) & 32'h7fffffff) % NP;
            drive_cycle(5'(1 << src), 100, 0, 0, '1);
            drain("xy_routing");
        end
        report_test("xy_routing", e);

        e = errors;
        repeat (400) drive_cycle('1, 60, 0, 1, '0);
        drain("random_traffic");
        check_value("random_model_empty", 1, model_empty());
        report_test("random_traffic", e);

        e = errors;
        start = acc_cnt[4];
        n = 0;
        drive_cycle(5'b10000, 100, 1, 0, 5'h1d);
        while (in_ready[4] && n < 50) begin
            drive_cycle(5'b10000, 100, 1, 0, 5'h1d);
            n++;
        end
        if (n >= 50) begin
            errors++;
            $display("Test back_pressure: in_ready on local never fell");
        end
        check_value("bp_accepted", `NOC_FIFO_DEPTH, acc_cnt[4] - start);
        drain("back_pressure");
        report_test("back_pressure", e);

        e = errors;
        east_src.delete();
        track_east = 1'b1;
        repeat (60) drive_cycle(5'b11000, 100, 1, 0, '1);
        drain("rr_fairness");
        track_east = 1'b0;
        check_value("rr_enough_flits", 1, east_src.size() >= 20);
        for (int k = 1; k < 20 && k < east_src.size(); k++) begin
            check_value("rr_alternate", 1, east_src[k] != east_src[k-1]);
        end
        report_test("rr_fairness", e);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
